/* rtl/branch_isa_pkg.sv */
// Branch instruction encodings shared by every block that decodes a branch word
`default_nettype none

package branch_isa_pkg;

	// ====================
	// Opcodes
	// ====================

	// Relational branches compare a against b in the class chosen by cm
	localparam logic [6:0] OP_BEQ = 7'h20;
	localparam logic [6:0] OP_BNE = 7'h21;
	localparam logic [6:0] OP_BLT = 7'h22;
	localparam logic [6:0] OP_BLE = 7'h23;
	localparam logic [6:0] OP_BGT = 7'h24;
	localparam logic [6:0] OP_BGE = 7'h25;
	// Bit test on a, with the bit index taken from the low six bits of b
	localparam logic [6:0] OP_BBS = 7'h26;
	// Multi-condition branch, the condition comes from the cnd field
	localparam logic [6:0] OP_MCB = 7'h27;

	// ====================
	// MCB sub-conditions
	// ====================

	// The code also serves as the bit position in the evaluator's condition vector
	localparam logic [2:0] MCB_EQ = 3'd0;
	localparam logic [2:0] MCB_NE = 3'd1;
	localparam logic [2:0] MCB_LT = 3'd2;
	localparam logic [2:0] MCB_LE = 3'd3;
	localparam logic [2:0] MCB_GT = 3'd4;
	localparam logic [2:0] MCB_GE = 3'd5;
	// In the float class these two become unordered and ordered
	localparam logic [2:0] MCB_BC = 3'd6;
	localparam logic [2:0] MCB_BS = 3'd7;

	// ====================
	// Comparison classes
	// ====================

	// Code 3 is left undefined and always resolves not-taken
	localparam logic [1:0] CM_SIGNED   = 2'd0;
	localparam logic [1:0] CM_UNSIGNED = 2'd1;
	localparam logic [1:0] CM_FLOAT    = 2'd2;

	// Plain branch layout, opcode in the low bits
	typedef struct packed {
		logic [22:0] disp;
		logic [1:0]  cm;
		logic [6:0]  opcode;
	} br_fmt_t;

	// Multi-condition layout, opcode and cm line up with the plain layout
	typedef struct packed {
		logic [19:0] disp;
		logic [2:0]  cnd;
		logic [1:0]  cm;
		logic [6:0]  opcode;
	} mcb_fmt_t;

	// One 32-bit word seen through either layout
	typedef union packed {
		br_fmt_t  br;
		mcb_fmt_t mcb;
	} instr_word_t;

endpackage

`default_nettype wire

/* rtl/branch_cfg_pkg.sv */
// Sizing constants for the branch resolution datapath, imported by the datapath modules
`default_nettype none

package branch_cfg_pkg;

	// ====================
	// Datapath sizing
	// ====================

	// Width of each operand, also the size of an IEEE-754 double
	localparam int VALUE_W = 64;

	// Number of evaluation units built by the top level
	localparam int NUM_EVAL_UNITS = 4;

	// Issue sequence width
	// Three bits cover the at most four branches that can be in flight
	localparam int SEQ_W = 3;

endpackage

`default_nettype wire

/* rtl/fp_compare.sv */
// Combinational double-precision comparator, instantiated inside each evaluation unit
`timescale 1ns/1ps
`default_nettype none

module fp_compare (
	input  wire logic [63:0] a,
	input  wire logic [63:0] b,
	output logic             eq,
	output logic             lt,
	output logic             le,
	output logic             unordered
);

	// A NaN has an all-ones exponent and a nonzero fraction
	logic nan_a;
	logic nan_b;
	// Both operands are zero, whatever their signs
	logic both_zero;
	// Magnitude compares ignore the sign bit
	logic mag_eq;
	logic mag_lt;
	logic eq_raw;
	logic lt_raw;

	assign nan_a = (&a[62:52]) & (|a[51:0]);
	assign nan_b = (&b[62:52]) & (|b[51:0]);
	assign unordered = nan_a | nan_b;

	assign both_zero = ~(|a[62:0]) & ~(|b[62:0]);
	assign mag_eq = a[62:0] == b[62:0];
	assign mag_lt = a[62:0] < b[62:0];

	// +0 and -0 compare equal, otherwise the bit patterns have to match
	assign eq_raw = both_zero | (a == b);

	always_comb begin
		if (both_zero)
			lt_raw = 1'b0;
		else begin
			case ({a[63], b[63]})
			// Both positive, the smaller magnitude is the smaller value
			2'b00:	lt_raw = mag_lt;
			// Negative against positive
			2'b10:	lt_raw = 1'b1;
			2'b01:	lt_raw = 1'b0;
			// Both negative, a larger magnitude is the smaller value
			default:	lt_raw = ~mag_lt & ~mag_eq;
			endcase
		end
	end

	// A NaN on either side makes every ordered relation false
	assign eq = ~unordered & eq_raw;
	assign lt = ~unordered & lt_raw;
	assign le = ~unordered & (lt_raw | eq_raw);

endmodule

`default_nettype wire

/* rtl/branch_eval_unit.sv */
// One branch evaluation slot: capture on start, resolve, hold the result until cleared
`timescale 1ns/1ps
`default_nettype none

module branch_eval_unit
	import branch_isa_pkg::*;
	import branch_cfg_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               start,
	input  wire instr_word_t        start_instr,
	input  wire logic [VALUE_W-1:0] start_a,
	input  wire logic [VALUE_W-1:0] start_b,
	input  wire logic [SEQ_W-1:0]   start_seq,
	input  wire logic               clear,
	output logic                    busy,
	output logic                    done,
	output logic                    taken,
	output logic [SEQ_W-1:0]        seq
);

	// Captured branch
	instr_word_t        instr_r;
	logic [VALUE_W-1:0] a_r;
	logic [VALUE_W-1:0] b_r;

	// Float comparator flags
	logic fp_eq;
	logic fp_lt;
	logic fp_le;
	logic fp_unord;

	// Per-class relations, then one bit per MCB condition code
	logic       cls_ok;
	logic       is_int;
	logic       c_eq;
	logic       c_lt;
	logic       c_le;
	logic       c_bs;
	logic [7:0] cond;
	logic       sel;

	// ====================
	// Capture and status
	// ====================

	always_ff @(posedge clk) begin
		if (start) begin
			instr_r <= start_instr;
			a_r <= start_a;
			b_r <= start_b;
			seq <= start_seq;
		end
	end

	// Done rises on the edge that captures the branch and holds until the collector clears it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			done <= 1'b0;
		else if (start)
			done <= 1'b1;
		else if (clear)
			done <= 1'b0;
	end

	// The slot is already taken during the start cycle itself
	assign busy = start | done;

	fp_compare fp_compare_i (
		.a(a_r),
		.b(b_r),
		.eq(fp_eq),
		.lt(fp_lt),
		.le(fp_le),
		.unordered(fp_unord)
	);

	// ====================
	// Decode
	// ====================

	always_comb begin
		cls_ok = 1'b1;
		is_int = 1'b1;
		c_eq = a_r == b_r;
		c_bs = a_r[b_r[5:0]];
		case (instr_r.br.cm)
		CM_SIGNED: begin
			c_lt = $signed(a_r) < $signed(b_r);
			c_le = $signed(a_r) <= $signed(b_r);
		end
		CM_UNSIGNED: begin
			c_lt = a_r < b_r;
			c_le = a_r <= b_r;
		end
		CM_FLOAT: begin
			is_int = 1'b0;
			c_eq = fp_eq;
			c_lt = fp_lt;
			c_le = fp_le;
			// Bit set turns into ordered in the float class
			c_bs = ~fp_unord;
		end
		default: begin
			cls_ok = 1'b0;
			is_int = 1'b0;
			c_lt = 1'b0;
			c_le = 1'b0;
		end
		endcase
	end

	// NE, GT and GE are inverses, so an unordered float compare takes all three
	always_comb begin
		cond[MCB_EQ] = c_eq;
		cond[MCB_NE] = ~c_eq;
		cond[MCB_LT] = c_lt;
		cond[MCB_LE] = c_le;
		cond[MCB_GT] = ~c_le;
		cond[MCB_GE] = ~c_lt;
		cond[MCB_BC] = ~c_bs;
		cond[MCB_BS] = c_bs;
	end

	// Plain opcodes pick a fixed condition, MCB reads cnd through the second view
	always_comb begin
		case (instr_r.br.opcode)
		OP_BEQ:	sel = cond[MCB_EQ];
		OP_BNE:	sel = cond[MCB_NE];
		OP_BLT:	sel = cond[MCB_LT];
		OP_BLE:	sel = cond[MCB_LE];
		OP_BGT:	sel = cond[MCB_GT];
		OP_BGE:	sel = cond[MCB_GE];
		// Bit test exists only in the integer classes
		OP_BBS:	sel = is_int & cond[MCB_BS];
		OP_MCB:	sel = cond[instr_r.mcb.cnd];
		default:	sel = 1'b0;
		endcase
	end

	assign taken = cls_ok & sel;

endmodule

`default_nettype wire

/* rtl/branch_dispatch.sv */
// Input handshake side: accepts branches, stamps sequence numbers and starts a free unit
`timescale 1ns/1ps
`default_nettype none

module branch_dispatch
	import branch_isa_pkg::*;
	import branch_cfg_pkg::*;
(
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      in_req,
	input  wire instr_word_t               in_instr,
	input  wire logic [VALUE_W-1:0]        in_a,
	input  wire logic [VALUE_W-1:0]        in_b,
	output logic                           in_ack,
	input  wire logic [NUM_EVAL_UNITS-1:0] busy,
	output logic [NUM_EVAL_UNITS-1:0]      start,
	output instr_word_t                    start_instr,
	output logic [VALUE_W-1:0]             start_a,
	output logic [VALUE_W-1:0]             start_b,
	output logic [SEQ_W-1:0]               start_seq
);

	logic [NUM_EVAL_UNITS-1:0] idle;
	// One-hot pick of the lowest-numbered idle unit
	logic [NUM_EVAL_UNITS-1:0] pick;
	logic                      accept;
	// Sequence number given to the next branch, wraps freely
	logic [SEQ_W-1:0]          seq_cnt;

	assign idle = ~busy;
	// Two's complement isolates the lowest set bit
	assign pick = idle & (~idle + 1'b1);

	// in_ack doubles as the state: low waits for a request, high waits for its release
	assign accept = in_req & ~in_ack & (|idle);

	// ====================
	// Handshake FSM
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_ack <= 1'b0;
			start <= '0;
			seq_cnt <= '0;
		end else begin
			// The start pulse lasts one cycle and goes out with the rising ack
			start <= accept ? pick : '0;
			if (accept) begin
				in_ack <= 1'b1;
				seq_cnt <= seq_cnt + 1'b1;
			end else if (in_ack && !in_req)
				in_ack <= 1'b0;
		end
	end

	// Branch data shared by all units, only the pulsed unit takes it
	always_ff @(posedge clk) begin
		if (accept) begin
			start_instr <= in_instr;
			start_a <= in_a;
			start_b <= in_b;
			start_seq <= seq_cnt;
		end
	end

endmodule

`default_nettype wire

/* rtl/branch_collect.sv */
// Output handshake side: returns finished results in issue order and frees their units
`timescale 1ns/1ps
`default_nettype none

module branch_collect
	import branch_cfg_pkg::*;
(
	input  wire logic                                 clk,
	input  wire logic                                 rst_n,
	input  wire logic [NUM_EVAL_UNITS-1:0]            done,
	input  wire logic [NUM_EVAL_UNITS-1:0]            taken,
	input  wire logic [NUM_EVAL_UNITS-1:0][SEQ_W-1:0] seq,
	output logic [NUM_EVAL_UNITS-1:0]                 clear,
	output logic                                      out_req,
	input  wire logic                                 out_ack,
	output logic                                      out_taken
);

	// Sequence number the sink has to see next
	logic [SEQ_W-1:0]          exp_seq;
	// Finished units holding exp_seq, at most one bit is set
	logic [NUM_EVAL_UNITS-1:0] match;
	// Unit whose result sits on the output port
	logic [NUM_EVAL_UNITS-1:0] owner;
	logic                      present;
	logic                      release_now;

	always_comb begin
		for (int i = 0; i < NUM_EVAL_UNITS; i++)
			match[i] = done[i] & (seq[i] == exp_seq);
	end

	// A new result goes out only once the previous ack has been dropped
	assign present = ~out_req & ~out_ack & (|match);
	assign release_now = out_req & out_ack;

	// ====================
	// Handshake FSM
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_req <= 1'b0;
			exp_seq <= '0;
			clear <= '0;
		end else begin
			// Clear pulses for one cycle on the edge that first sees the ack
			clear <= release_now ? owner : '0;
			if (present)
				out_req <= 1'b1;
			else if (release_now) begin
				out_req <= 1'b0;
				exp_seq <= exp_seq + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (present) begin
			owner <= match;
			out_taken <= |(match & taken);
		end
	end

endmodule

`default_nettype wire

/* rtl/branch_resolve_top.sv */
// Top of the branch resolution block, wiring the dispatcher, the evaluation units and the collector
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_top
	import branch_isa_pkg::*;
	import branch_cfg_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               in_req,
	input  wire instr_word_t        in_instr,
	input  wire logic [VALUE_W-1:0] in_a,
	input  wire logic [VALUE_W-1:0] in_b,
	output logic                    in_ack,
	output logic                    out_req,
	input  wire logic               out_ack,
	output logic                    out_taken
);

	// Dispatcher to units
	logic [NUM_EVAL_UNITS-1:0]            start;
	instr_word_t                          start_instr;
	logic [VALUE_W-1:0]                   start_a;
	logic [VALUE_W-1:0]                   start_b;
	logic [SEQ_W-1:0]                     start_seq;
	logic [NUM_EVAL_UNITS-1:0]            busy;

	// Units to collector and back
	logic [NUM_EVAL_UNITS-1:0]            done;
	logic [NUM_EVAL_UNITS-1:0]            taken;
	logic [NUM_EVAL_UNITS-1:0][SEQ_W-1:0] seq;
	logic [NUM_EVAL_UNITS-1:0]            clear;

	branch_dispatch branch_dispatch_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req),
		.in_instr(in_instr),
		.in_a(in_a),
		.in_b(in_b),
		.in_ack(in_ack),
		.busy(busy),
		.start(start),
		.start_instr(start_instr),
		.start_a(start_a),
		.start_b(start_b),
		.start_seq(start_seq)
	);

	// Identical slots, each one owns its bit of the start, done and clear vectors
	for (genvar i = 0; i < NUM_EVAL_UNITS; i++) begin : g_unit
		branch_eval_unit branch_eval_unit_i (
			.clk(clk),
			.rst_n(rst_n),
			.start(start[i]),
			.start_instr(start_instr),
			.start_a(start_a),
			.start_b(start_b),
			.start_seq(start_seq),
			.clear(clear[i]),
			.busy(busy[i]),
			.done(done[i]),
			.taken(taken[i]),
			.seq(seq[i])
		);
	end

	branch_collect branch_collect_i (
		.clk(clk),
		.rst_n(rst_n),
		.done(done),
		.taken(taken),
		.seq(seq),
		.clear(clear),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_taken(out_taken)
	);

endmodule

`default_nettype wire

/* sim/branch_clock_gen.sv */
// Testbench clock and power-on reset source, instantiated once by the branch resolution testbench
`timescale 1ns/1ps
`default_nettype none

module branch_clock_gen (
	output logic clk,
	output logic rst_n
);

	// Free-running clock with an 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset stays low for 16 rising edges and is released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* sim/branch_resolve_checker.sv */
// Handshake assertions for the branch resolution top level, attached to it with bind by the testbench
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_checker (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_req,
	input wire logic in_ack,
	input wire logic out_req,
	input wire logic out_ack,
	input wire logic out_taken
);

	// ====================
	// Input port
	// ====================

	// An acknowledge only ever answers a pending request
	ack_needs_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(in_ack) |-> $past(in_req)
	) else $error("in_ack rose while in_req was low");

	// ====================
	// Output port
	// ====================

	// The result must not change while the sink may still be reading it
	taken_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_req && $past(out_req) |-> $stable(out_taken)
	) else $error("out_taken changed while out_req was high");

	// A request is held until the sink answers it
	req_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_req && !out_ack |=> out_req
	) else $error("out_req dropped before out_ack was seen");

	// Both handshakes come out of reset idle
	reset_idle: assert property (
		@(posedge clk)
		$rose(rst_n) |-> !in_ack && !out_req
	) else $error("in_ack or out_req high when reset was released");

endmodule

`default_nettype wire

/* sim/branch_resolve_tb.sv */
// Testbench for the branch resolution block that drives both handshake ports and checks every result
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_tb
	import branch_isa_pkg::*;
	import branch_cfg_pkg::*;
();

	localparam int WAIT_LIMIT = 1000;
	localparam int DRAIN_LIMIT = 5000;
	localparam int SETTLE_CYCLES = 64;

	logic               clk;
	logic               rst_n;
	logic               in_req;
	instr_word_t        in_instr;
	logic [VALUE_W-1:0] in_a;
	logic [VALUE_W-1:0] in_b;
	logic               in_ack;
	logic               out_req;
	logic               out_ack;
	logic               out_taken;

	// Expected results in issue order that the source pushes and the sink pops
	logic        exp_q [$];
	int          seed = 41631;
	int          max_delay = 6;
	int          issued = 0;
	int          received = 0;
	int          errors = 0;
	int          test_num = 0;
	int          issued_base = 0;
	int          errors_base = 0;
	logic        timed_out = 1'b0;
	logic [6:0]  rel_ops [6];
	logic [6:0]  all_ops [8];
	logic [63:0] int_a [8];
	logic [63:0] int_b [8];
	logic [63:0] fp_a [10];
	logic [63:0] fp_b [10];

	branch_clock_gen branch_clock_gen_i (
		.clk(clk),
		.rst_n(rst_n)
	);

	branch_resolve_top branch_resolve_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req),
		.in_instr(in_instr),
		.in_a(in_a),
		.in_b(in_b),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_taken(out_taken)
	);

	bind branch_resolve_top branch_resolve_checker branch_resolve_checker_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_taken(out_taken)
	);

	// ====================
	// Reference model
	// ====================

	function automatic logic is_nan(logic [63:0] v);
		return (v[62:52] == 11'h7FF) && (v[51:0] != 52'd0);
	endfunction

	// Decides a branch straight from the ISA rules
	function automatic logic predict_taken(instr_word_t w, logic [63:0] a, logic [63:0] b);
		logic [2:0] c;
		logic       bit_set;
		logic       unord;
		logic       lt;
		logic       gt;
		real        ra;
		real        rb;
		bit_set = a[b[5:0]];
		if (w.br.cm == 2'd3)
			return 1'b0;
		case (w.br.opcode)
		OP_BEQ:	c = MCB_EQ;
		OP_BNE:	c = MCB_NE;
		OP_BLT:	c = MCB_LT;
		OP_BLE:	c = MCB_LE;
		OP_BGT:	c = MCB_GT;
		OP_BGE:	c = MCB_GE;
		OP_BBS:	return (w.br.cm != CM_FLOAT) && bit_set;
		OP_MCB:	c = w.mcb.cnd;
		default:	return 1'b0;
		endcase
		if (w.br.cm == CM_FLOAT) begin
			// Any relation with a NaN is unordered, so only NE, GT and GE hold
			unord = is_nan(a) || is_nan(b);
			ra = $bitstoreal(a);
			rb = $bitstoreal(b);
			case (c)
			MCB_EQ:	return !unord && (ra == rb);
			MCB_NE:	return unord || (ra != rb);
			MCB_LT:	return !unord && (ra < rb);
			MCB_LE:	return !unord && (ra <= rb);
			MCB_GT:	return unord || (ra > rb);
			MCB_GE:	return unord || (ra >= rb);
			MCB_BC:	return unord;
			default:	return !unord;
			endcase
		end
		if (w.br.cm == CM_SIGNED) begin
			lt = $signed(a) < $signed(b);
			gt = $signed(a) > $signed(b);
		end else begin
			lt = a < b;
			gt = a > b;
		end
		case (c)
		MCB_EQ:	return a == b;
		MCB_NE:	return a != b;
		MCB_LT:	return lt;
		MCB_LE:	return !gt;
		MCB_GT:	return gt;
		MCB_GE:	return !lt;
		MCB_BC:	return !bit_set;
		default:	return bit_set;
		endcase
	endfunction

	// Random displacement bits around the fields under test
	function automatic instr_word_t instr_of(logic [6:0] op, logic [1:0] cm, logic [2:0] cnd);
		instr_word_t w;
		w = $random(seed);
		w.mcb.opcode = op;
		w.mcb.cm = cm;
		if (op == OP_MCB)
			w.mcb.cnd = cnd;
		return w;
	endfunction

	// ====================
	// Source side
	// ====================

	task automatic wait_in_ack(logic level);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (in_ack !== level && !timed_out) begin
			cnt++;
			if (cnt > WAIT_LIMIT) begin
				$display("Timeout: in_ack did not reach %0b within %0d cycles", level, WAIT_LIMIT);
				timed_out = 1'b1;
			end else
				@(negedge clk);
		end
	endtask

	task automatic send_branch(instr_word_t w, logic [63:0] a, logic [63:0] b);
		if (!timed_out) begin
			exp_q.push_back(predict_taken(w, a, b));
			issued++;
			@(posedge clk);
			in_req <= 1'b1;
			in_instr <= w;
			in_a <= a;
			in_b <= b;
			wait_in_ack(1'b1);
			@(posedge clk);
			in_req <= 1'b0;
			wait_in_ack(1'b0);
		end
	endtask

	// Waits until every issued branch has come back and then prints the test line
	task automatic close_test(string name);
		int cnt;
		cnt = 0;
		while (received < issued && !timed_out) begin
			cnt++;
			if (cnt > DRAIN_LIMIT) begin
				$display("Timeout: %0d results missing in test %s", issued - received, name);
				timed_out = 1'b1;
			end else
				@(negedge clk);
		end
		test_num++;
		$display("Test %0d %s: %0d branches, %0d errors", test_num, name,
			issued - issued_base, errors - errors_base);
		issued_base = issued;
		errors_base = errors;
	endtask

	task automatic fill_operands();
		rel_ops = '{OP_BEQ, OP_BNE, OP_BLT, OP_BLE, OP_BGT, OP_BGE};
		all_ops = '{OP_BEQ, OP_BNE, OP_BLT, OP_BLE, OP_BGT, OP_BGE, OP_BBS, OP_MCB};
		// Pairs that differ only in sign and the most negative against the most positive
		int_a[0] = 64'h0000_0000_0000_0005;
		int_b[0] = 64'hFFFF_FFFF_FFFF_FFFB;
		int_a[1] = 64'hFFFF_FFFF_FFFF_FFFF;
		int_b[1] = 64'h0000_0000_0000_0001;
		int_a[2] = 64'h8000_0000_0000_0000;
		int_b[2] = 64'h7FFF_FFFF_FFFF_FFFF;
		int_a[3] = 64'h0000_0000_0000_1234;
		int_b[3] = 64'h0000_0000_0000_1234;
		for (int p = 4; p < 8; p++) begin
			int_a[p] = {$random(seed), $random(seed)};
			int_b[p] = {$random(seed), $random(seed)};
		end
		// Signed zeros, NaNs on either side, infinities and two negatives
		fp_a[0] = 64'h0000_0000_0000_0000;
		fp_b[0] = 64'h8000_0000_0000_0000;
		fp_a[1] = 64'h8000_0000_0000_0000;
		fp_b[1] = 64'h0000_0000_0000_0000;
		fp_a[2] = 64'h3FF8_0000_0000_0000;
		fp_b[2] = 64'hC000_0000_0000_0000;
		fp_a[3] = 64'hC000_0000_0000_0000;
		fp_b[3] = 64'h3FF8_0000_0000_0000;
		fp_a[4] = 64'h7FF8_0000_0000_0001;
		fp_b[4] = 64'h3FF0_0000_0000_0000;
		fp_a[5] = 64'h3FF0_0000_0000_0000;
		fp_b[5] = 64'hFFF8_0000_0000_0000;
		fp_a[6] = 64'hFFF0_0000_0000_0000;
		fp_b[6] = 64'h7FF0_0000_0000_0000;
		fp_a[7] = 64'h3FF0_0000_0000_0000;
		fp_b[7] = 64'h3FF0_0000_0000_0000;
		fp_a[8] = 64'hBFF0_0000_0000_0000;
		fp_b[8] = 64'hC000_0000_0000_0000;
		fp_a[9] = {$random(seed), $random(seed)};
		fp_b[9] = {$random(seed), $random(seed)};
	endtask

	// ====================
	// Tests
	// ====================

	task automatic relational_pairs(logic [1:0] cm);
		for (int p = 0; p < 8; p++) begin
			for (int k = 0; k < 6; k++) begin
				send_branch(instr_of(rel_ops[k], cm, 3'd0), int_a[p], int_b[p]);
				send_branch(instr_of(OP_MCB, cm, k[2:0]), int_a[p], int_b[p]);
			end
		end
	endtask

	task automatic float_pairs();
		for (int p = 0; p < 10; p++) begin
			for (int k = 0; k < 6; k++)
				send_branch(instr_of(rel_ops[k], CM_FLOAT, 3'd0), fp_a[p], fp_b[p]);
			for (int k = 0; k < 8; k++)
				send_branch(instr_of(OP_MCB, CM_FLOAT, k[2:0]), fp_a[p], fp_b[p]);
			send_branch(instr_of(OP_BBS, CM_FLOAT, 3'd0), fp_a[p], fp_b[p]);
		end
	endtask

	task automatic random_bit_tests();
		logic [63:0] a;
		logic [63:0] b;
		logic [1:0]  cm;
		for (int n = 0; n < 16; n++) begin
			a = {$random(seed), $random(seed)};
			b = {$random(seed), $random(seed)};
			cm = n[0] ? CM_UNSIGNED : CM_SIGNED;
			send_branch(instr_of(OP_BBS, cm, 3'd0), a, b);
			send_branch(instr_of(OP_MCB, cm, MCB_BS), a, b);
			send_branch(instr_of(OP_MCB, cm, MCB_BC), a, b);
		end
	endtask

	// Equal all-ones operands would take EQ, LE, GE and the bit test if decoded
	task automatic undefined_encodings();
		logic [6:0] bad_ops [3];
		bad_ops = '{7'h00, 7'h28, 7'h7F};
		for (int k = 0; k < 3; k++) begin
			for (int cm = 0; cm < 4; cm++)
				send_branch(instr_of(bad_ops[k], cm[1:0], 3'd0), '1, '1);
		end
		for (int k = 0; k < 8; k++)
			send_branch(instr_of(all_ops[k], 2'd3, k[2:0]), '1, '1);
	endtask

	task automatic backpressure_burst();
		int k;
		int cm;
		max_delay = 20;
		for (int n = 0; n < 40; n++) begin
			k = $unsigned($random(seed)) % 8;
			cm = $unsigned($random(seed)) % 3;
			send_branch(instr_of(all_ops[k], cm[1:0], 3'($random(seed))),
				{$random(seed), $random(seed)}, {$random(seed), $random(seed)});
		end
		max_delay = 6;
	endtask

	// ====================
	// Sink side
	// ====================

	initial begin : sink
		int   cnt;
		int   delay;
		logic expected;
		while (!timed_out) begin
			cnt = 0;
			@(negedge clk);
			// Idle time only counts while a result is owed
			while (!out_req && !timed_out) begin
				if (exp_q.size() != 0)
					cnt++;
				if (cnt > WAIT_LIMIT) begin
					$display("Timeout: no result while %0d were pending", exp_q.size());
					timed_out = 1'b1;
				end else
					@(negedge clk);
			end
			if (!timed_out) begin
				// Every returned result counts, including one that nobody asked for
				received++;
				if (exp_q.size() == 0) begin
					$display("Extra result: out_req rose with no branch outstanding");
					errors++;
				end else begin
					expected = exp_q.pop_front();
					assert (out_taken === expected) else begin
						$display("CHECK FAILED out_taken: got %h, expected %h", out_taken, expected);
						errors++;
					end
				end
				delay = $unsigned($random(seed)) % (max_delay + 1);
				repeat (delay) @(posedge clk);
				@(posedge clk);
				out_ack <= 1'b1;
				cnt = 0;
				@(negedge clk);
				while (out_req && !timed_out) begin
					cnt++;
					if (cnt > WAIT_LIMIT) begin
						$display("Timeout: out_req stayed high after out_ack");
						timed_out = 1'b1;
					end else
						@(negedge clk);
				end
				@(posedge clk);
				out_ack <= 1'b0;
			end
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial begin : source
		int cnt;
		in_req = 1'b0;
		in_instr = '0;
		in_a = '0;
		in_b = '0;
		out_ack = 1'b0;
		fill_operands();
		cnt = 0;
		while (rst_n !== 1'b1 && !timed_out) begin
			cnt++;
			if (cnt > 100) begin
				$display("Timeout: reset was never released");
				timed_out = 1'b1;
			end else
				@(negedge clk);
		end
		relational_pairs(CM_SIGNED);
		close_test("signed relational and MCB");
		relational_pairs(CM_UNSIGNED);
		close_test("unsigned relational and MCB");
		float_pairs();
		close_test("float relational and MCB");
		random_bit_tests();
		close_test("integer bit tests");
		undefined_encodings();
		close_test("undefined opcode and class");
		backpressure_burst();
		close_test("sink back-pressure");
		// A duplicated result would still show up once the last one has been acknowledged
		for (int n = 0; n < SETTLE_CYCLES; n++)
			@(negedge clk);
		// One result per branch and nothing left over means nothing was lost or duplicated
		assert (exp_q.size() == 0 && received == issued) else begin
			$display("Lost or duplicated results: %0d branches issued, %0d results returned",
				issued, received);
			errors++;
		end
		$display("Summary: %0d tests, %0d branches, %0d returned, %0d errors", test_num,
			issued, received, errors);
		if (errors == 0 && !timed_out)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
rtl/branch_isa_pkg.sv
rtl/branch_cfg_pkg.sv
rtl/fp_compare.sv
rtl/branch_eval_unit.sv
rtl/branch_dispatch.sv
rtl/branch_collect.sv
rtl/branch_resolve_top.sv
sim/branch_clock_gen.sv
sim/branch_resolve_checker.sv
sim/branch_resolve_tb.sv

/* Makefile */
TOP := branch_resolve_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
